//--- array_if.sv
/*
 * one set-indexed storage array seen from the controller
 * rdata follows idx in the same cycle, a write lands on the next edge
 */
`timescale 1ns/100ps
`default_nettype none

interface array_if #(parameter type entry_t = logic);
    import l1_cache_pkg::*;

    logic [SET_BITS-1:0] idx;   // set select
    logic                wen;
    entry_t              wdata; // whole entry, no partial writes
    entry_t              rdata;

    modport ctrl  (output idx, wen, wdata, input rdata);
    modport store (input idx, wen, wdata, output rdata);

endinterface

`default_nettype wire

//--- cache_array.sv
/*
 * set-indexed storage, one entry per set
 * combinational read, whole-entry write on the rising edge
 * contents are undefined after reset until the controller sweeps them
 */
`timescale 1ns/100ps
`default_nettype none

module cache_array #(
    parameter type entry_t = logic
) (
    input logic    CLK,
    array_if.store bus
);
    import l1_cache_pkg::*;

    entry_t mem [N_SETS];

    always_ff @(posedge CLK) begin
        if (bus.wen) begin
            mem[bus.idx] <= bus.wdata;
        end
    end

    assign bus.rdata = mem[bus.idx]; // read sees the old entry during a write

endmodule

`default_nettype wire

//--- cache_ctrl.sv
/*
 * processor side of the cache: hit check, byte merge, miss and flush handling
 * a request must be held until cpu_busy is low, cpu_ren and cpu_wen never together
 * flush is latched and served once no request is pending
 * busy for N_SETS cycles after reset while all tags are cleared
 */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                cpu_ren,
    input  logic                cpu_wen,
    input  logic                flush,
    input  l1_cache_pkg::word_t cpu_addr,
    input  l1_cache_pkg::word_t cpu_wdata,
    input  logic [3:0]          cpu_byte_en,
    output l1_cache_pkg::word_t cpu_rdata,
    output logic                cpu_busy,
    output logic                flush_done,
    array_if.ctrl               tag_bus,
    array_if.ctrl               data_bus,
    mem_xfer_if.ctrl            xfer
);
    import l1_cache_pkg::*;

    ctrl_state_t         state, next_state;
    logic [SET_BITS-1:0] sweep_cnt;   // shared by reset sweep and flush
    logic [SET_BITS-1:0] set_sel;
    logic                sweep_step, sweep_last;
    logic                flush_pend;
    logic                req_gap;     // keeps req low one cycle after done
    logic                want_job;
    logic                access, uncached, hit;
    logic                array_wen;
    cache_addr_t         caddr;
    tag_entry_t          tag_rd, tag_wdata;
    line_t               line_rd, line_merged, data_wdata;

    function automatic word_t line_base(input logic [TAG_BITS-1:0] ltag,
                                        input logic [SET_BITS-1:0] lidx);
        cache_addr_t a;
        a = '{tag: ltag, idx: lidx, word: '0, byte_off: '0};
        return word_t'(a);
    endfunction

    assign caddr      = cache_addr_t'(cpu_addr);
    assign tag_rd     = tag_bus.rdata;
    assign line_rd    = data_bus.rdata;
    assign access     = cpu_ren || cpu_wen;
    assign uncached   = cpu_addr >= NONCACHE_BASE;
    assign hit        = tag_rd.valid && (tag_rd.tag == caddr.tag) && !uncached;
    assign sweep_last = sweep_cnt == SET_BITS'(N_SETS - 1);

    // both arrays always look at the same set
    assign set_sel        = (state == INIT || state == FLUSH) ? sweep_cnt : caddr.idx;
    assign tag_bus.idx    = set_sel;
    assign data_bus.idx   = set_sel;
    assign tag_bus.wen    = array_wen;
    assign data_bus.wen   = array_wen;
    assign tag_bus.wdata  = tag_wdata;
    assign data_bus.wdata = data_wdata;

    assign xfer.req     = want_job && !req_gap;
    assign xfer.wline   = line_rd;
    assign xfer.wword   = cpu_wdata;
    assign xfer.byte_en = cpu_byte_en;

    // write hit data, only enabled lanes of the addressed word change
    always_comb begin
        line_merged = line_rd;
        for (int i = 0; i < 4; i++) begin
            if (cpu_byte_en[i]) begin
                line_merged[caddr.word][8*i +: 8] = cpu_wdata[8*i +: 8];
            end
        end
    end

    always_comb begin
        next_state = state;
        want_job   = 1'b0;
        xfer.op    = OP_FILL;
        xfer.addr  = line_base(caddr.tag, caddr.idx);
        array_wen  = 1'b0;
        tag_wdata  = tag_rd;
        data_wdata = line_rd;
        cpu_busy   = 1'b1;
        cpu_rdata  = line_rd[caddr.word];
        flush_done = 1'b0;
        sweep_step = 1'b0;

        case (state)
            INIT: begin
                array_wen  = 1'b1;
                tag_wdata  = '0;
                sweep_step = 1'b1;
                if (sweep_last) begin
                    next_state = READY;
                end
            end
            READY: begin
                if (access && uncached) begin
                    next_state = SINGLE;
                end else if (access && hit) begin
                    cpu_busy = 1'b0;
                    if (cpu_wen) begin
                        array_wen       = 1'b1;
                        data_wdata      = line_merged;
                        tag_wdata.dirty = 1'b1;
                    end
                end else if (access) begin
                    // victim is the only line of the set
                    next_state = (tag_rd.valid && tag_rd.dirty) ? EVICT : FILL;
                end else if (flush_pend) begin
                    next_state = FLUSH;
                end
            end
            EVICT: begin
                want_job  = 1'b1;
                xfer.op   = OP_EVICT;
                xfer.addr = line_base(tag_rd.tag, caddr.idx);
                if (xfer.done) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                want_job = 1'b1;
                if (xfer.done) begin
                    array_wen  = 1'b1;
                    data_wdata = xfer.rline;
                    tag_wdata  = '{valid: 1'b1, dirty: 1'b0, tag: caddr.tag};
                    next_state = READY; // request then retires as a hit
                end
            end
            SINGLE: begin
                want_job  = 1'b1;
                xfer.op   = cpu_wen ? OP_SINGLE_WR : OP_SINGLE_RD;
                xfer.addr = cpu_addr;
                if (xfer.done) begin
                    cpu_busy   = 1'b0;
                    cpu_rdata  = xfer.rword;
                    next_state = READY;
                end
            end
            FLUSH: begin
                xfer.op   = OP_EVICT;
                xfer.addr = line_base(tag_rd.tag, sweep_cnt);
                want_job  = tag_rd.valid && tag_rd.dirty;
                if (!want_job || xfer.done) begin
                    array_wen  = 1'b1;
                    tag_wdata  = '0;
                    sweep_step = 1'b1;
                    if (sweep_last) begin
                        flush_done = 1'b1;
                        next_state = READY;
                    end
                end
            end
            default: next_state = INIT;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= INIT;
            sweep_cnt  <= '0;
            flush_pend <= 1'b0;
            req_gap    <= 1'b0;
        end else begin
            state   <= next_state;
            req_gap <= xfer.done;
            if (sweep_step) begin
                sweep_cnt <= sweep_cnt + 1'b1; // wraps to 0 after the last set
            end
            if (flush) begin
                flush_pend <= 1'b1;
            end else if (state == READY && next_state == FLUSH) begin
                flush_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- cache_trace.txt
# columns: name op addr data byte_en expected (numbers in hex)
# ops: R read and compare, W write, F flush, C compare the memory word
rd_miss_w0    R 00000040 00000000 f A5A5A5E5
rd_hit_w1     R 00000044 00000000 f A5A5A5E1
wr_lane1      W 00000044 0000BE00 2 00000000
rd_lane1      R 00000044 00000000 f A5A5BEE1
wr_dirty      W 00000080 11223344 f 00000000
rd_conflict   R 00000180 00000000 f A5A5A425
chk_evict_w0  C 00000080 00000000 f 11223344
chk_evict_w1  C 00000084 00000000 f A5A5A521
wr_uncached   W F0000010 DEADBEEF c 00000000
chk_uncached  C F0000010 00000000 f DEAD0000
rd_uncached   R F0000020 00000000 f 55A5A585
wr_f0         W 00000100 CAFE0001 f 00000000
wr_f1         W 00000208 CAFE0002 f 00000000
wr_f2         W 000000F4 CAFE0003 f 00000000
flush_all     F 00000000 00000000 0 00000000
chk_f0        C 00000100 00000000 f CAFE0001
chk_f1        C 00000208 00000000 f CAFE0002
chk_f2        C 000000F4 00000000 f CAFE0003
chk_lane1     C 00000044 00000000 f A5A5BEE1
rd_after_fl   R 00000208 00000000 f CAFE0002

//--- l1_cache.sv
/*
 * direct-mapped write-back L1 data cache, 256 bytes in 2-word lines
 * processor and memory requests are held until their busy signal is low
 * addresses from F000_0000 up pass through as single words
 */
`timescale 1ns/100ps
`default_nettype none

module l1_cache (
    input  logic                CLK,
    input  logic                nRST,
    // processor side
    input  logic                cpu_ren,
    input  logic                cpu_wen,
    input  l1_cache_pkg::word_t cpu_addr,
    input  l1_cache_pkg::word_t cpu_wdata,
    input  logic [3:0]          cpu_byte_en,
    output l1_cache_pkg::word_t cpu_rdata,
    output logic                cpu_busy,
    input  logic                flush,
    output logic                flush_done,
    // memory side
    output logic                mem_ren,
    output logic                mem_wen,
    output l1_cache_pkg::word_t mem_addr,
    output l1_cache_pkg::word_t mem_wdata,
    output logic [3:0]          mem_byte_en,
    input  l1_cache_pkg::word_t mem_rdata,
    input  logic                mem_busy
);
    import l1_cache_pkg::*;

    array_if #(.entry_t(tag_entry_t)) tag_bus ();
    array_if #(.entry_t(line_t))      data_bus ();
    mem_xfer_if                       xfer_bus ();

    cache_ctrl ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .cpu_ren     (cpu_ren),
        .cpu_wen     (cpu_wen),
        .flush       (flush),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_byte_en (cpu_byte_en),
        .cpu_rdata   (cpu_rdata),
        .cpu_busy    (cpu_busy),
        .flush_done  (flush_done),
        .tag_bus     (tag_bus.ctrl),
        .data_bus    (data_bus.ctrl),
        .xfer        (xfer_bus.ctrl)
    );

    cache_array #(.entry_t(tag_entry_t)) tag_store (
        .CLK (CLK),
        .bus (tag_bus.store)
    );

    cache_array #(.entry_t(line_t)) data_store (
        .CLK (CLK),
        .bus (data_bus.store)
    );

    mem_xfer xfer_eng (
        .CLK         (CLK),
        .nRST        (nRST),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .xfer        (xfer_bus.xfer)
    );

endmodule

`default_nettype wire

//--- l1_cache_asserts.sv
/*
 * bus protocol checks, bound into every l1_cache instance
 * all checks are idle while nRST is low
 */
`timescale 1ns/100ps
`default_nettype none

module l1_cache_asserts (
    input logic                CLK,
    input logic                nRST,
    input logic                cpu_ren,
    input logic                cpu_wen,
    input logic                cpu_busy,
    input logic                flush_done,
    input logic                mem_ren,
    input logic                mem_wen,
    input logic                mem_busy,
    input l1_cache_pkg::word_t mem_addr,
    input l1_cache_pkg::word_t mem_wdata
);

    mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high together");

    // a stalled beat keeps its fields
    mem_beat_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=> $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory beat changed while mem_busy was high");

    cpu_ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        !cpu_busy |-> (cpu_ren || cpu_wen))
        else $error("cpu_busy low with no request");

    flush_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else $error("flush_done high for more than one cycle");

endmodule

bind l1_cache l1_cache_asserts asserts (
    .CLK        (CLK),
    .nRST       (nRST),
    .cpu_ren    (cpu_ren),
    .cpu_wen    (cpu_wen),
    .cpu_busy   (cpu_busy),
    .flush_done (flush_done),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_busy   (mem_busy),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
);

`default_nettype wire

//--- l1_cache_pkg.sv
/*
 * sizes, address fields and shared types of the L1 data cache
 * capacity and line size must stay powers of two, N_SETS is derived
 * word addressing is little endian, byte lane i is bits 8*i+7 down to 8*i
 */
`default_nettype none

package l1_cache_pkg;

    localparam int unsigned WORD_W      = 32;
    localparam int unsigned CACHE_BYTES = 256;
    localparam int unsigned BLOCK_WORDS = 2;
    localparam int unsigned N_SETS      = CACHE_BYTES / (BLOCK_WORDS * (WORD_W / 8));

    localparam int unsigned SET_BITS   = $clog2(N_SETS);
    localparam int unsigned BLOCK_BITS = $clog2(BLOCK_WORDS);
    localparam int unsigned TAG_BITS   = WORD_W - SET_BITS - BLOCK_BITS - 2;

    typedef logic [WORD_W-1:0] word_t;
    typedef word_t [BLOCK_WORDS-1:0] line_t;

    localparam word_t NONCACHE_BASE = 32'hF000_0000; // everything above bypasses the array

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   idx;
        logic [BLOCK_BITS-1:0] word;
        logic [1:0]            byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    // memory jobs handed to the transfer engine
    typedef enum logic [1:0] {
        OP_FILL,
        OP_EVICT,
        OP_SINGLE_RD,
        OP_SINGLE_WR
    } xfer_op_t;

    typedef enum logic [2:0] {
        INIT,
        READY,
        EVICT,
        FILL,
        SINGLE,
        FLUSH
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- mem_xfer.sv
/*
 * memory side engine, runs one job at a time as single-word beats
 * a beat is held until mem_busy is low, line jobs take BLOCK_WORDS beats
 * a job is picked up only while idle, so the first beat starts a cycle after req
 */
`timescale 1ns/100ps
`default_nettype none

module mem_xfer (
    input  logic                CLK,
    input  logic                nRST,
    input  l1_cache_pkg::word_t mem_rdata,
    input  logic                mem_busy,
    output logic                mem_ren,
    output logic                mem_wen,
    output l1_cache_pkg::word_t mem_addr,
    output l1_cache_pkg::word_t mem_wdata,
    output logic [3:0]          mem_byte_en,
    mem_xfer_if.xfer            xfer
);
    import l1_cache_pkg::*;

    logic                  run;       // job accepted, beats on the bus
    logic [BLOCK_BITS-1:0] beat;
    line_t                 fill_q;    // words of the line collected so far
    logic                  single, last_beat, beat_done;
    cache_addr_t           beat_addr;

    assign single    = (xfer.op == OP_SINGLE_RD) || (xfer.op == OP_SINGLE_WR);
    assign last_beat = single || (beat == BLOCK_BITS'(BLOCK_WORDS - 1));
    assign beat_done = run && !mem_busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            run  <= 1'b0;
            beat <= '0;
        end else if (!run) begin
            run  <= xfer.req;
            beat <= '0;
        end else if (beat_done) begin
            if (last_beat) begin
                run  <= 1'b0;
                beat <= '0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (beat_done && mem_ren) begin
            fill_q[beat] <= mem_rdata;
        end
    end

    // line jobs walk the word field, singles keep the full address
    always_comb begin
        beat_addr = cache_addr_t'(xfer.addr);
        if (!single) begin
            beat_addr.word     = beat;
            beat_addr.byte_off = 2'b00;
        end
    end

    always_comb begin
        mem_wdata = '0;
        if (xfer.op == OP_EVICT) begin
            mem_wdata = xfer.wline[beat];
        end else if (xfer.op == OP_SINGLE_WR) begin
            for (int i = 0; i < 4; i++) begin
                if (xfer.byte_en[i]) begin
                    mem_wdata[8*i +: 8] = xfer.wword[8*i +: 8]; // other lanes stay zero
                end
            end
        end
    end

    assign mem_ren     = run && (xfer.op == OP_FILL || xfer.op == OP_SINGLE_RD);
    assign mem_wen     = run && (xfer.op == OP_EVICT || xfer.op == OP_SINGLE_WR);
    assign mem_addr    = word_t'(beat_addr);
    assign mem_byte_en = single ? xfer.byte_en : 4'hF;

    // last word goes straight through so the line is whole in the done cycle
    always_comb begin
        xfer.rline       = fill_q;
        xfer.rline[beat] = mem_rdata;
    end

    assign xfer.rword = mem_rdata;
    assign xfer.done  = beat_done && last_beat;

endmodule

`default_nettype wire

//--- mem_xfer_if.sv
/*
 * job channel from the cache controller to the memory transfer engine
 * req is a level, all job fields stay put until done
 * req drops in the cycle after the done pulse
 */
`timescale 1ns/100ps
`default_nettype none

interface mem_xfer_if;
    import l1_cache_pkg::*;

    logic       req;
    xfer_op_t   op;
    word_t      addr;     // line base for line jobs
    line_t      wline;    // victim line for evictions
    word_t      wword;    // single write data
    logic [3:0] byte_en;
    line_t      rline;    // complete only in the done cycle
    word_t      rword;
    logic       done;

    modport ctrl (
        output req, op, addr, wline, wword, byte_en,
        input  rline, rword, done
    );

    modport xfer (
        input  req, op, addr, wline, wword, byte_en,
        output rline, rword, done
    );

endinterface

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_l1_cache -Mdir "$BUILD_DIR" -o tb_l1_cache -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_l1_cache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0

//--- tb_l1_cache.sv
/*
 * stimulus and expected words for the L1 data cache come from cache_trace.txt
 * memory model answers each beat after 0 to 3 wait cycles
 * untouched memory words read as their address XOR A5A5_A5A5
 * memory stores whole words and expects the DUT to zero lanes outside byte_en
 */
`timescale 1ns/100ps
`default_nettype none

module tb_l1_cache;
    import l1_cache_pkg::*;

    localparam int    CLK_PERIOD    = 8;
    localparam int    RESET_CYCLES  = 16;
    localparam int    CYCLES_PER_OP = 200;
    localparam word_t FILL_KEY      = 32'hA5A5_A5A5;

    logic       CLK;
    logic       nRST;
    logic       cpu_ren, cpu_wen, flush;
    word_t      cpu_addr, cpu_wdata, cpu_rdata;
    logic [3:0] cpu_byte_en;
    logic       cpu_busy, flush_done;
    logic       mem_ren, mem_wen, mem_busy;
    word_t      mem_addr, mem_wdata, mem_rdata;
    logic [3:0] mem_byte_en;

    // one entry per trace line
    logic [8*24-1:0] t_name [$];
    logic [7:0]      t_op [$];
    word_t           t_addr [$];
    word_t           t_data [$];
    logic [3:0]      t_be [$];
    word_t           t_exp [$];

    word_t mem_words [word_t]; // written words only
    int    wait_left;
    logic  in_beat;
    int    cycle_cnt   = 0;
    int    cycle_limit = 0;
    int    cur_line    = 0;   // trace line being run
    int    bus_errs    = 0;
    int    n_tests, n_fail;

    l1_cache dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .cpu_ren     (cpu_ren),
        .cpu_wen     (cpu_wen),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_byte_en (cpu_byte_en),
        .cpu_rdata   (cpu_rdata),
        .cpu_busy    (cpu_busy),
        .flush       (flush),
        .flush_done  (flush_done),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic word_t mem_read(input word_t addr);
        word_t a;
        a = {addr[31:2], 2'b00};
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return a ^ FILL_KEY;
    endfunction

    // uncached beats carry the request lanes and line beats carry all four
    task automatic check_lanes();
        logic [3:0] exp_be;
        exp_be = (mem_addr >= NONCACHE_BASE) ? t_be[cur_line] : 4'hF;
        if (mem_byte_en !== exp_be) begin
            $display("Mismatch in %0s: mem_byte_en expected %h, actual %h",
                     t_name[cur_line], exp_be, mem_byte_en);
            bus_errs++;
        end
    endtask

    // memory model decides everything on the falling edge
    always @(negedge CLK) begin
        if (mem_ren || mem_wen) begin
            if (!in_beat) begin
                in_beat   = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left > 0) begin
                wait_left = wait_left - 1;
                mem_busy  = 1'b1;
            end else begin
                in_beat  = 1'b0;
                mem_busy = 1'b0; // beat completes at the next rising edge
                check_lanes();
                if (mem_ren) begin
                    mem_rdata = mem_read(mem_addr);
                end else begin
                    mem_words[{mem_addr[31:2], 2'b00}] = mem_wdata;
                end
            end
        end else begin
            in_beat  = 1'b0;
            mem_busy = 1'b1;
        end
    end

    always @(posedge CLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic load_trace(output bit ok);
        int              fd;
        int              code;
        string           line;
        logic [8*24-1:0] name_v;
        logic [7:0]      op_v;
        word_t           addr_v, data_v, exp_v;
        logic [3:0]      be_v;
        ok = 1'b0;
        fd = $fopen("cache_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open cache_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%s %s %h %h %h %h",
                                   name_v, op_v, addr_v, data_v, be_v, exp_v);
                    if (code == 6) begin
                        t_name.push_back(name_v);
                        t_op.push_back(op_v);
                        t_addr.push_back(addr_v);
                        t_data.push_back(data_v);
                        t_be.push_back(be_v);
                        t_exp.push_back(exp_v);
                    end
                end
            end
            $fclose(fd);
            ok = t_op.size() > 0;
            if (!ok) begin
                $display("cache_trace.txt holds no operations");
            end
        end
    endtask

    // request held until a cycle with cpu_busy low
    task automatic cpu_access(input bit is_write, input word_t addr, input word_t data,
                              input logic [3:0] be, output word_t rdata);
        @(negedge CLK);
        cpu_ren     = !is_write;
        cpu_wen     = is_write;
        cpu_addr    = addr;
        cpu_wdata   = data;
        cpu_byte_en = be;
        #1;
        while (cpu_busy) begin
            @(negedge CLK);
            #1;
        end
        rdata = cpu_rdata;
        @(negedge CLK);
        cpu_ren = 1'b0;
        cpu_wen = 1'b0;
    endtask

    task automatic flush_cache();
        @(negedge CLK);
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        #1;
        while (!flush_done) begin
            @(negedge CLK);
            #1;
        end
    endtask

    task automatic run_line(input int i);
        word_t got;
        bit    bad;
        int    errs_before;
        bad         = 1'b0;
        got         = '0;
        errs_before = bus_errs;
        case (t_op[i])
            "R": begin
                cpu_access(1'b0, t_addr[i], t_data[i], t_be[i], got);
                if (got !== t_exp[i]) begin
                    $display("Mismatch in %0s: expected %h, actual %h", t_name[i], t_exp[i], got);
                    bad = 1'b1;
                end
            end
            "W": cpu_access(1'b1, t_addr[i], t_data[i], t_be[i], got);
            "F": flush_cache();
            "C": begin
                got = mem_read(t_addr[i]);
                if (got !== t_exp[i]) begin
                    $display("Mismatch in %0s: expected %h, actual %h", t_name[i], t_exp[i], got);
                    bad = 1'b1;
                end
            end
            default: begin
                $display("test %0s has an unknown operation %s", t_name[i], t_op[i]);
                bad = 1'b1;
            end
        endcase
        if (bus_errs != errs_before) begin
            bad = 1'b1;
        end
        n_tests++;
        if (bad) begin
            n_fail++;
            $display("test %0s failed", t_name[i]);
        end else begin
            $display("test %0s ok", t_name[i]);
        end
    endtask

    initial begin
        bit trace_ok;
        void'($urandom(13));
        nRST        = 1'b0;
        cpu_ren     = 1'b0;
        cpu_wen     = 1'b0;
        flush       = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_byte_en = 4'h0;
        mem_busy    = 1'b1;
        mem_rdata   = '0;
        in_beat     = 1'b0;
        wait_left   = 0;
        n_tests     = 0;
        n_fail      = 0;

        load_trace(trace_ok);
        if (trace_ok) begin
            cycle_limit = RESET_CYCLES + N_SETS + CYCLES_PER_OP * t_op.size();
            repeat (RESET_CYCLES) @(negedge CLK);
            nRST = 1'b1;
            foreach (t_op[i]) begin
                cur_line = i;
                run_line(i);
            end
        end

        $display("tests: %0d, failed: %0d", n_tests, n_fail);
        if (trace_ok && n_fail == 0 && bus_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
l1_cache_pkg.sv
array_if.sv
mem_xfer_if.sv
cache_array.sv
cache_ctrl.sv
mem_xfer.sv
l1_cache.sv
l1_cache_asserts.sv
tb_l1_cache.sv
